// File: Makefile
VERILATOR = verilator
TOP       = joiner_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass message in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/channel_arbiter.sv
`default_nettype none

module channel_arbiter (
  input  wire logic                                  clk,
  input  wire logic                                  int_rst,
  input  wire logic                                  interrupt,
  input  wire logic [joiner_pkg::channels-1:0]       request,
  input  wire logic [joiner_pkg::channels-1:0]       acknowledge,
  output logic      [joiner_pkg::channels-1:0]       grant,
  output logic                                       grant_valid,
  output logic      [joiner_pkg::chan_idx_width-1:0] grant_index
);

  import joiner_pkg::*;

  logic [channels-1:0] grant_keep;

  // Lowest numbered set bit wins
  function automatic logic [channels-1:0] lowest_first(input logic [channels-1:0] req);
    logic [channels-1:0] pick;
    logic                found;
    pick  = '0;
    found = 1'b0;
    for (int i = 0; i < channels; i++) begin
      if (req[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
    return pick;
  endfunction

  // Current grant survives while it is still requested and not acknowledged
  assign grant_keep = grant & request & ~acknowledge;

  always_ff @(posedge clk) begin
    if (int_rst || interrupt) begin
      grant <= '0;
    end else if (grant_valid && (grant_keep != '0)) begin
      grant <= grant;
    end else begin
      // Released or empty, pick the next lowest remaining request
      grant <= lowest_first(request & ~acknowledge);
    end
  end

  assign grant_valid = |grant;

  // One-hot to binary
  always_comb begin
    grant_index = '0;
    for (int i = 0; i < channels; i++) begin
      if (grant[i]) begin
        grant_index = chan_idx_width'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/joiner_pkg.sv
`default_nettype none

package joiner_pkg;

  // Channel count and beat geometry
  localparam int channels = 3;
  localparam int data_width = 16;
  localparam int keep_width = data_width / 8;

  // Encoded channel number, at least one bit wide
  localparam int chan_idx_width = (channels > 1) ? $clog2(channels) : 1;

  // Operation states
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_oper  = 2'd1,
    st_error = 2'd2,
    st_done  = 2'd3
  } joiner_state_t;

endpackage

`default_nettype wire

// File: hdl/joiner_top.sv
`default_nettype none

module joiner_top (
  input  wire logic                                                   clk,
  input  wire logic                                                   int_rst,
  input  wire logic                                                   interrupt,
  input  wire logic                                                   operation_start,
  input  wire logic [joiner_pkg::channels-1:0]                        use_channels,
  input  wire logic [joiner_pkg::channels*joiner_pkg::data_width-1:0] s_data,
  input  wire logic [joiner_pkg::channels*joiner_pkg::keep_width-1:0] s_keep,
  input  wire logic [joiner_pkg::channels-1:0]                        s_valid,
  input  wire logic [joiner_pkg::channels-1:0]                        s_last,
  output logic      [joiner_pkg::channels-1:0]                        s_ready,
  output logic      [joiner_pkg::data_width-1:0]                      m_data,
  output logic      [joiner_pkg::keep_width-1:0]                      m_keep,
  output logic                                                        m_valid,
  input  wire logic                                                   m_ready,
  output logic                                                        m_last,
  output logic                                                        operation_busy,
  output logic                                                        operation_complete,
  output logic                                                        operation_error,
  output logic                                                        transmission
);

  import joiner_pkg::*;

  logic [channels-1:0]       valid_gated;
  logic [channels-1:0]       mux_ready;
  logic [channels-1:0]       request;
  logic [channels-1:0]       acknowledge;
  logic [channels-1:0]       grant;
  logic                      grant_valid;
  logic [chan_idx_width-1:0] grant_index;
  logic                      final_flag;
  logic                      final_out;

  // Registered joined stream
  stream_if out_stream ();

  packet_joiner u_joiner (
    .clk                (clk),
    .int_rst            (int_rst),
    .interrupt          (interrupt),
    .operation_start    (operation_start),
    .use_channels       (use_channels),
    .s_valid            (s_valid),
    .s_last             (s_last),
    .s_ready            (s_ready),
    .valid_gated        (valid_gated),
    .mux_ready          (mux_ready),
    .request            (request),
    .acknowledge        (acknowledge),
    .grant              (grant),
    .m_stream           (out_stream),
    .m_ready            (m_ready),
    .final_out          (final_out),
    .final_flag         (final_flag),
    .m_last             (m_last),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .transmission       (transmission)
  );

  channel_arbiter u_arbiter (
    .clk         (clk),
    .int_rst     (int_rst),
    .interrupt   (interrupt),
    .request     (request),
    .acknowledge (acknowledge),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_index (grant_index)
  );

  stream_mux u_mux (
    .clk         (clk),
    .int_rst     (int_rst),
    .interrupt   (interrupt),
    .s_data      (s_data),
    .s_keep      (s_keep),
    .s_valid     (valid_gated),
    .s_last      (s_last),
    .s_ready     (mux_ready),
    .final_in    (final_flag),
    .grant_valid (grant_valid),
    .grant_index (grant_index),
    .m_stream    (out_stream),
    .final_out   (final_out)
  );

  assign m_data  = out_stream.data;
  assign m_keep  = out_stream.keep;
  assign m_valid = out_stream.valid;

endmodule

`default_nettype wire

// File: hdl/packet_joiner.sv
`default_nettype none

module packet_joiner (
  input  wire logic                            clk,
  input  wire logic                            int_rst,
  input  wire logic                            interrupt,
  input  wire logic                            operation_start,
  input  wire logic [joiner_pkg::channels-1:0] use_channels,
  input  wire logic [joiner_pkg::channels-1:0] s_valid,
  input  wire logic [joiner_pkg::channels-1:0] s_last,
  output logic      [joiner_pkg::channels-1:0] s_ready,
  output logic      [joiner_pkg::channels-1:0] valid_gated,
  input  wire logic [joiner_pkg::channels-1:0] mux_ready,
  output logic      [joiner_pkg::channels-1:0] request,
  output logic      [joiner_pkg::channels-1:0] acknowledge,
  input  wire logic [joiner_pkg::channels-1:0] grant,
  stream_if.sink                               m_stream,
  input  wire logic                            m_ready,
  input  wire logic                            final_out,
  output logic                                 final_flag,
  output logic                                 m_last,
  output logic                                 operation_busy,
  output logic                                 operation_complete,
  output logic                                 operation_error,
  output logic                                 transmission
);

  import joiner_pkg::*;

  joiner_state_t       state;
  joiner_state_t       state_next;
  logic [channels-1:0] mask;
  logic [channels-1:0] busy_vec;
  logic                out_xfer;
  logic                last_xfer;

  // Status straight from the state register
  assign operation_busy     = (state == st_oper);
  assign operation_complete = (state == st_done);
  assign operation_error    = (state == st_error);

  // Selected channels only, and only during an operation
  assign busy_vec    = {channels{operation_busy}} & mask;
  assign valid_gated = busy_vec & s_valid;
  assign s_ready     = busy_vec & mux_ready;

  // Last beat of a packet accepted on the granted channel
  assign acknowledge = s_last & valid_gated & mux_ready & grant;
  assign request     = mask;

  // No channel left once this acknowledge lands
  assign final_flag = ((mask & ~acknowledge) == '0);

  assign m_stream.ready = m_ready;
  assign m_last         = m_stream.last && final_out;
  assign out_xfer       = m_stream.valid && m_stream.ready;
  assign last_xfer      = out_xfer && m_last;

  always_comb begin
    state_next = state;
    case (state)
      st_idle, st_done: begin
        if (operation_start) begin
          state_next = (use_channels != '0) ? st_oper : st_error;
        end else begin
          state_next = st_idle;
        end
      end
      st_oper: begin
        if (last_xfer) begin
          state_next = st_done;
        end
      end
      st_error: begin
        state_next = st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
    // Abort wins over everything
    if (interrupt) begin
      state_next = st_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (int_rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Mask latched at start, shrinks by one channel per acknowledge
  always_ff @(posedge clk) begin
    if (int_rst) begin
      mask <= '0;
    end else begin
      case (state_next)
        st_oper: begin
          if (state != st_oper) begin
            mask <= use_channels;
          end else begin
            mask <= mask & ~acknowledge;
          end
        end
        default: begin
          mask <= '0;
        end
      endcase
    end
  end

  // Flags the cycle after each output transfer
  always_ff @(posedge clk) begin
    if (int_rst) begin
      transmission <= 1'b0;
    end else begin
      transmission <= out_xfer;
    end
  end

endmodule

`default_nettype wire

// File: hdl/stream_if.sv
`default_nettype none

interface stream_if;

  // One beat of the joined stream
  logic [joiner_pkg::data_width-1:0] data;
  logic [joiner_pkg::keep_width-1:0] keep;
  logic                              valid;
  logic                              ready;
  logic                              last;

  // Side that produces beats
  modport source (
    output data,
    output keep,
    output valid,
    output last,
    input  ready
  );

  // Side that consumes beats
  modport sink (
    input  data,
    input  keep,
    input  valid,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/stream_mux.sv
`default_nettype none

module stream_mux (
  input  wire logic                                             clk,
  input  wire logic                                             int_rst,
  input  wire logic                                             interrupt,
  input  wire logic [joiner_pkg::channels*joiner_pkg::data_width-1:0] s_data,
  input  wire logic [joiner_pkg::channels*joiner_pkg::keep_width-1:0] s_keep,
  input  wire logic [joiner_pkg::channels-1:0]                  s_valid,
  input  wire logic [joiner_pkg::channels-1:0]                  s_last,
  output logic      [joiner_pkg::channels-1:0]                  s_ready,
  input  wire logic                                             final_in,
  input  wire logic                                             grant_valid,
  input  wire logic [joiner_pkg::chan_idx_width-1:0]            grant_index,
  stream_if.source                                              m_stream,
  output logic                                                  final_out
);

  import joiner_pkg::*;

  logic                  in_ready;
  logic                  sel_valid;
  logic [data_width-1:0] sel_data;
  logic [keep_width-1:0] sel_keep;
  logic                  sel_last;

  // Output register
  logic                  out_valid;
  logic [data_width-1:0] out_data;
  logic [keep_width-1:0] out_keep;
  logic                  out_last;
  logic                  out_final;

  // Room for a new beat when empty or draining this cycle
  assign in_ready = !out_valid || m_stream.ready;

  // Route the granted channel, others see ready low
  always_comb begin
    sel_valid = 1'b0;
    sel_data  = '0;
    sel_keep  = '0;
    sel_last  = 1'b0;
    s_ready   = '0;
    for (int i = 0; i < channels; i++) begin
      if (grant_valid && (i == int'(grant_index))) begin
        sel_valid  = s_valid[i];
        sel_data   = s_data[i*data_width +: data_width];
        sel_keep   = s_keep[i*keep_width +: keep_width];
        sel_last   = s_last[i];
        s_ready[i] = in_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (int_rst || interrupt) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= sel_valid;
    end
  end

  // Payload and final flag move together
  always_ff @(posedge clk) begin
    if (in_ready && sel_valid) begin
      out_data  <= sel_data;
      out_keep  <= sel_keep;
      out_last  <= sel_last;
      out_final <= final_in;
    end
  end

  assign m_stream.valid = out_valid;
  assign m_stream.data  = out_data;
  assign m_stream.keep  = out_keep;
  assign m_stream.last  = out_last;
  assign final_out      = out_final;

endmodule

`default_nettype wire

// File: sources.f
hdl/joiner_pkg.sv
hdl/stream_if.sv
hdl/channel_arbiter.sv
hdl/stream_mux.sv
hdl/packet_joiner.sv
hdl/joiner_top.sv
test/joiner_checker.sv
test/joiner_tb.sv

// File: test/joiner_checker.sv
`default_nettype none

module joiner_checker (
  input wire logic                            clk,
  input wire logic                            int_rst,
  input wire logic                            interrupt,
  input wire logic                            operation_start,
  input wire logic [joiner_pkg::channels-1:0] use_channels,
  input wire logic [joiner_pkg::channels-1:0] s_ready,
  input wire logic [joiner_pkg::data_width-1:0] m_data,
  input wire logic [joiner_pkg::keep_width-1:0] m_keep,
  input wire logic                            m_valid,
  input wire logic                            m_ready,
  input wire logic                            m_last,
  input wire logic                            operation_busy,
  input wire logic                            operation_complete,
  input wire logic                            operation_error,
  input wire logic                            transmission
);

  timeunit 1ns;
  timeprecision 100ps;

  import joiner_pkg::*;

  logic [channels-1:0] selected;

  // Channels accepted by the last start that was taken
  always @(posedge clk) begin
    if (int_rst) begin
      selected <= '0;
    end else if (operation_start && !operation_busy && !operation_error) begin
      selected <= use_channels;
    end
  end

  // Output beat holds while stalled
  a_hold: assert property (@(posedge clk) disable iff (int_rst)
    (m_valid && !m_ready && !interrupt) |=>
      (m_valid && $stable(m_data) && $stable(m_keep) && $stable(m_last)))
    else $error("output beat changed while stalled");

  // Only selected channels, and only while busy
  a_gate: assert property (@(posedge clk) disable iff (int_rst)
    (s_ready & ~(selected & {channels{operation_busy}})) == '0)
    else $error("s_ready high on a channel outside the operation");

  a_excl: assert property (@(posedge clk) disable iff (int_rst)
    !(operation_complete && operation_error))
    else $error("complete and error high together");

  a_tx: assert property (@(posedge clk) disable iff (int_rst)
    transmission == $past(m_valid && m_ready))
    else $error("transmission does not follow a transfer by one cycle");

  // Complete comes right after the final beat, in the cycle busy falls
  a_done: assert property (@(posedge clk) disable iff (int_rst)
    operation_complete |->
      (!operation_busy && $past(operation_busy) && $past(m_valid && m_ready && m_last)))
    else $error("complete pulse without a final transfer before it");

endmodule

bind joiner_top joiner_checker u_checker (
  .clk                (clk),
  .int_rst            (int_rst),
  .interrupt          (interrupt),
  .operation_start    (operation_start),
  .use_channels       (use_channels),
  .s_ready            (s_ready),
  .m_data             (m_data),
  .m_keep             (m_keep),
  .m_valid            (m_valid),
  .m_ready            (m_ready),
  .m_last             (m_last),
  .operation_busy     (operation_busy),
  .operation_complete (operation_complete),
  .operation_error    (operation_error),
  .transmission       (transmission)
);

`default_nettype wire

// File: test/joiner_tb.sv
`default_nettype none

module joiner_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import joiner_pkg::*;

  localparam int timeout_cycles = 3000;
  localparam int beat_width = data_width + keep_width + 1;

  logic                             clk;
  logic                             int_rst;
  logic                             interrupt;
  logic                             operation_start;
  logic [channels-1:0]              use_channels;
  logic [channels*data_width-1:0]   s_data;
  logic [channels*keep_width-1:0]   s_keep;
  logic [channels-1:0]              s_valid;
  logic [channels-1:0]              s_last;
  logic [channels-1:0]              s_ready;
  logic [data_width-1:0]            m_data;
  logic [keep_width-1:0]            m_keep;
  logic                             m_valid;
  logic                             m_ready;
  logic                             m_last;
  logic                             operation_busy;
  logic                             operation_complete;
  logic                             operation_error;
  logic                             transmission;

  // Beat layout is {last, keep, data}
  logic [beat_width-1:0] src_q[channels][$];
  logic [beat_width-1:0] exp_q[$];
  bit                    random_ready;
  int                    beat_count;
  string                 test_name;

  joiner_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_plain(input string what);
    $display("%s: %s", test_name, what);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // Source drivers for all channels, valid held until accepted
  always @(posedge clk) begin : source_engine
    bit accepted;
    for (int ch = 0; ch < channels; ch++) begin
      accepted = s_valid[ch] && s_ready[ch];
      if (accepted) begin
        void'(src_q[ch].pop_front());
      end
      if (src_q[ch].size() > 0 && ((s_valid[ch] && !accepted) || ($urandom % 3 != 0))) begin
        s_data[ch*data_width +: data_width] <= src_q[ch][0][data_width-1:0];
        s_keep[ch*keep_width +: keep_width] <= src_q[ch][0][data_width +: keep_width];
        s_last[ch]  <= src_q[ch][0][beat_width-1];
        s_valid[ch] <= 1'b1;
      end else begin
        s_valid[ch] <= 1'b0;
      end
    end
  end

  // Sink and scoreboard
  always @(posedge clk) begin : sink_check
    logic [beat_width-1:0] exp;
    m_ready <= random_ready ? ($urandom % 4 != 0) : 1'b1;
    if (!int_rst && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        fail_plain("output beat arrived with nothing expected");
      end else begin
        exp = exp_q.pop_front();
        beat_count++;
        assert (m_data == exp[data_width-1:0])
          else fail_value("m_data", 32'(exp[data_width-1:0]), 32'(m_data));
        assert (m_keep == exp[data_width +: keep_width])
          else fail_value("m_keep", 32'(exp[data_width +: keep_width]), 32'(m_keep));
        assert (m_last == exp[beat_width-1])
          else fail_value("m_last", 32'(exp[beat_width-1]), 32'(m_last));
      end
    end
  end

  // Fresh packet on every channel, expected beats for the masked ones
  task automatic load_packets(input logic [channels-1:0] mask);
    int                    top;
    int                    len;
    logic [beat_width-1:0] beat;
    top = 0;
    for (int ch = 0; ch < channels; ch++) begin
      if (mask[ch]) top = ch;
    end
    exp_q.delete();
    for (int ch = 0; ch < channels; ch++) begin
      src_q[ch].delete();
      len = 1 + $urandom % 5;
      for (int b = 0; b < len; b++) begin
        // Channel number in the top bits marks where a beat came from
        beat[data_width-1:0] = {2'(ch), 14'($urandom)};
        beat[data_width +: keep_width] = keep_width'(($urandom % 3) + 1);
        beat[beat_width-1] = (b == len - 1);
        src_q[ch].push_back(beat);
        if (mask[ch]) begin
          beat[beat_width-1] = (b == len - 1) && (ch == top);
          exp_q.push_back(beat);
        end
      end
    end
  endtask

  task automatic start_op(input logic [channels-1:0] mask);
    @(negedge clk);
    load_packets(mask);
    @(posedge clk);
    operation_start <= 1'b1;
    use_channels    <= mask;
    @(posedge clk);
    operation_start <= 1'b0;
  endtask

  task automatic wait_complete();
    int n;
    n = 0;
    while (!operation_complete) begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles) fail_plain("timeout waiting for operation complete");
    end
    assert (exp_q.size() == 0) else fail_value("beats missing", 0, exp_q.size());
  endtask

  task automatic clear_stimulus();
    @(negedge clk);
    exp_q.delete();
    for (int ch = 0; ch < channels; ch++) src_q[ch].delete();
  endtask

  initial begin : sequence_main
    int n;
    int first_count;
    void'($urandom(32'h9645d7d8));
    int_rst         <= 1'b1;
    interrupt       <= 1'b0;
    operation_start <= 1'b0;
    use_channels    <= '0;
    s_data          <= '0;
    s_keep          <= '0;
    s_valid         <= '0;
    s_last          <= '0;
    m_ready         <= 1'b0;
    random_ready    = 0;
    beat_count      = 0;
    test_name       = "reset";
    repeat (16) @(posedge clk);
    int_rst <= 1'b0;
    repeat (2) @(posedge clk);

    test_name = "joined_content";
    start_op(3'b101);
    wait_complete();
    for (int i = 0; i < 6; i++) begin
      start_op(3'(($urandom % 7) + 1));
      wait_complete();
    end

    test_name = "back_pressure";
    random_ready = 1;
    for (int i = 0; i < 8; i++) begin
      start_op(3'(($urandom % 7) + 1));
      wait_complete();
    end

    // Zero mask, all sources offering data
    test_name = "error_path";
    start_op(3'b000);
    n = 0;
    while (!operation_error) begin
      @(posedge clk);
      n++;
      if (n > 20) fail_plain("timeout waiting for the error pulse");
    end
    repeat (4) begin
      @(posedge clk);
      assert (!operation_busy && !operation_error && !m_valid && s_ready == '0)
        else fail_plain("activity after a zero mask start");
    end
    clear_stimulus();
    start_op(3'b011);
    wait_complete();

    test_name = "interrupt";
    first_count = beat_count;
    start_op(3'b111);
    // Top channel never sends its final beat, so the operation stays open
    @(negedge clk);
    void'(src_q[channels-1].pop_back());
    n = 0;
    while (beat_count < first_count + 2) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) fail_plain("timeout waiting for beats before the interrupt");
    end
    @(posedge clk);
    interrupt <= 1'b1;
    @(posedge clk);
    interrupt <= 1'b0;
    clear_stimulus();
    @(posedge clk);
    assert (!operation_busy && !m_valid && s_ready == '0)
      else fail_plain("joiner still active after the interrupt");
    start_op(3'b110);
    wait_complete();

    repeat (4) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
